// File: dv/kt_input.txt
# per test: priority and prefix length, then the prefix as x y pairs,
# then the 25 expected tour squares as x y pairs
6 25
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 4 2 3 4 1 3 0 1 2 2
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 4 2 3 4 1 3 0 1 2 2
6 21
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 4 2
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 4 2 3 4 1 3 0 1 2 2
0 20
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 2 2 0 1 1 3 3 4 4 2
1 20
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 4 2 3 4 2 2 0 1 1 3
3 20
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 2 2 0 1 1 3 3 4 4 2
7 20
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 2 2 0 1 1 3 3 4 4 2
2 24
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 4 2 3 4 1 3 0 1
0 0 2 1 4 0 3 2 4 4 2 3 0 4 1 2 2 0 4 1 3 3 1 4 0 2
1 0 3 1 4 3 2 4 0 3 1 1 3 0 4 2 3 4 1 3 0 1 2 2

// File: src.f
logic/kt_pkg.sv
logic/kt_path_if.sv
logic/kt_path_store.sv
logic/kt_move_gen.sv
logic/kt_search.sv
logic/kt_playback.sv
logic/kt_top.sv
dv/kt_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal -j 0
TOP      := kt_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/kt_tb.sv
`timescale 1ns/1ps
`default_nettype none

module kt_tb;

    localparam int MAX_TESTS    = 16;
    localparam int N            = kt_pkg::NUM_SQUARES;
    localparam int WATCH_CYCLES = 2000000;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic [2:0] in_x;
    logic [2:0] in_y;
    logic [2:0] priority_num;
    logic       out_valid;
    logic [2:0] out_x;
    logic [2:0] out_y;
    logic [4:0] move_out;

    int num_tests;
    int t_prio [MAX_TESTS];
    int t_len  [MAX_TESTS];
    int t_px   [MAX_TESTS][N];
    int t_py   [MAX_TESTS][N];
    int t_ex   [MAX_TESTS][N];
    int t_ey   [MAX_TESTS][N];
    int got_x  [N];
    int got_y  [N];
    int mismatches;
    int failures;
    bit loaded;

    kt_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_x         (in_x),
        .in_y         (in_y),
        .priority_num (priority_num),
        .out_valid    (out_valid),
        .out_x        (out_x),
        .out_y        (out_y),
        .move_out     (move_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // the limit grows with the number of tests read from the vector file
    initial begin
        int limit;
        wait (loaded);
        limit = ((num_tests > 0) ? num_tests : 1) * WATCH_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // returns the next number in the vector file and skips lines opening with #
    task automatic read_num(input int fd, output int val, output bit ok);
        string tok;
        string rest;
        int    code;
        bit    done;
        ok   = 1'b0;
        val  = 0;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $sscanf(tok, "%d", val);
                ok   = (code == 1);
                done = 1'b1;
            end
        end
    endtask

    task automatic load_vectors();
        int fd;
        int v;
        bit ok;
        bit more;
        num_tests = 0;
        fd = $fopen("dv/kt_input.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open the vector file dv/kt_input.txt");
        end else begin
            more = 1'b1;
            while (more && num_tests < MAX_TESTS) begin
                read_num(fd, t_prio[num_tests], ok);
                if (!ok) begin
                    more = 1'b0;
                end else begin
                    read_num(fd, t_len[num_tests], ok);
                    for (int i = 0; i < t_len[num_tests]; i++) begin
                        read_num(fd, t_px[num_tests][i], ok);
                        read_num(fd, t_py[num_tests][i], ok);
                    end
                    for (int i = 0; i < N; i++) begin
                        read_num(fd, t_ex[num_tests][i], ok);
                        read_num(fd, v, ok);
                        t_ey[num_tests][i] = v;
                    end
                    if (!ok) begin
                        failures++;
                        $display("Vector file ends in the middle of test %0d", num_tests);
                        more = 1'b0;
                    end else begin
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_idle_outputs();
        if (out_valid !== 1'b0) begin
            mismatches++;
            $display("Mismatch: out_valid = 0x%h, expected 0x0 while idle", out_valid);
        end
        if (out_x !== 3'h0) begin
            mismatches++;
            $display("Mismatch: out_x = 0x%h, expected 0x0 while idle", out_x);
        end
        if (out_y !== 3'h0) begin
            mismatches++;
            $display("Mismatch: out_y = 0x%h, expected 0x0 while idle", out_y);
        end
        if (move_out !== 5'h0) begin
            mismatches++;
            $display("Mismatch: move_out = 0x%h, expected 0x0 while idle", move_out);
        end
    endtask

    // priority only counts on the first cycle, so later cycles carry noise
    task automatic drive_prefix(input int t);
        for (int i = 0; i < t_len[t]; i++) begin
            in_valid     = 1'b1;
            in_x         = 3'(t_px[t][i]);
            in_y         = 3'(t_py[t][i]);
            priority_num = (i == 0) ? 3'(t_prio[t]) : 3'($urandom_range(7, 0));
            @(negedge clk);
            check_idle_outputs();
        end
        in_valid     = 1'b0;
        in_x         = 3'h0;
        in_y         = 3'h0;
        priority_num = 3'h0;
    endtask

    task automatic collect_tour(input int t);
        while (out_valid !== 1'b1) begin
            check_idle_outputs();
            @(negedge clk);
        end
        for (int k = 1; k <= N; k++) begin
            if (out_valid !== 1'b1) begin
                failures++;
                $display("Test %0d: out_valid dropped before step %0d", t, k);
            end
            if (move_out !== 5'(k)) begin
                mismatches++;
                $display("Mismatch: move_out = 0x%h, expected 0x%h (test %0d)", move_out,
                         5'(k), t);
            end
            if (out_x !== 3'(t_ex[t][k-1])) begin
                mismatches++;
                $display("Mismatch: out_x = 0x%h, expected 0x%h (test %0d step %0d)", out_x,
                         3'(t_ex[t][k-1]), t, k);
            end
            if (out_y !== 3'(t_ey[t][k-1])) begin
                mismatches++;
                $display("Mismatch: out_y = 0x%h, expected 0x%h (test %0d step %0d)", out_y,
                         3'(t_ey[t][k-1]), t, k);
            end
            got_x[k-1] = int'(out_x);
            got_y[k-1] = int'(out_y);
            @(negedge clk);
        end
        if (out_valid !== 1'b0) begin
            failures++;
            $display("Test %0d: out_valid stayed high after 25 cycles", t);
        end
        check_idle_outputs();
    endtask

    // tour rules checked on the received squares alone
    task automatic check_tour(input int t);
        bit seen [N];
        int dx;
        int dy;
        for (int i = 0; i < N; i++) begin
            seen[i] = 1'b0;
        end
        for (int i = 0; i < t_len[t]; i++) begin
            if (got_x[i] != t_px[t][i] || got_y[i] != t_py[t][i]) begin
                failures++;
                $display("Test %0d: step %0d does not keep the given prefix square", t, i + 1);
            end
        end
        for (int i = 0; i < N; i++) begin
            if (got_x[i] >= kt_pkg::BOARD_N || got_y[i] >= kt_pkg::BOARD_N) begin
                failures++;
                $display("Test %0d: step %0d lies off the board", t, i + 1);
            end else if (seen[got_y[i] * kt_pkg::BOARD_N + got_x[i]]) begin
                failures++;
                $display("Test %0d: step %0d visits a square a second time", t, i + 1);
            end else begin
                seen[got_y[i] * kt_pkg::BOARD_N + got_x[i]] = 1'b1;
            end
            if (i > 0) begin
                dx = (got_x[i] > got_x[i-1]) ? got_x[i] - got_x[i-1] : got_x[i-1] - got_x[i];
                dy = (got_y[i] > got_y[i-1]) ? got_y[i] - got_y[i-1] : got_y[i-1] - got_y[i];
                if (!((dx == 1 && dy == 2) || (dx == 2 && dy == 1))) begin
                    failures++;
                    $display("Test %0d: step %0d is not a knight move away from the step before",
                             t, i + 1);
                end
            end
        end
    endtask

    initial begin
        int gap;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_x         = 3'h0;
        in_y         = 3'h0;
        priority_num = 3'h0;
        mismatches   = 0;
        failures     = 0;
        loaded       = 1'b0;
        void'($urandom(32'h710c));
        load_vectors();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        for (int t = 0; t < num_tests; t++) begin
            // the second test always follows right after the first playback
            gap = (t == 1) ? 0 : int'($urandom_range(3, 0));
            repeat (gap) begin
                @(negedge clk);
                check_idle_outputs();
            end
            drive_prefix(t);
            collect_tour(t);
            check_tour(t);
        end
        $display("Summary: %0d tests, %0d mismatches, %0d other errors", num_tests,
                 mismatches, failures);
        if (mismatches == 0 && failures == 0 && num_tests > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/kt_top.sv
`timescale 1ns/1ps
`default_nettype none

module kt_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        in_valid,
    input  wire [kt_pkg::COORD_W-1:0]  in_x,
    input  wire [kt_pkg::COORD_W-1:0]  in_y,
    input  wire [kt_pkg::DIR_W-1:0]    priority_num,
    output logic                       out_valid,
    output logic [kt_pkg::COORD_W-1:0] out_x,
    output logic [kt_pkg::COORD_W-1:0] out_y,
    output logic [kt_pkg::STEP_W-1:0]  move_out
);

    logic play_go;
    logic play_done;

    kt_path_if path ();

    kt_path_store i_store (
        .clk   (clk),
        .rst_n (rst_n),
        .path  (path.store)
    );

    // search fills the stack, playback drains it by step
    kt_search i_search (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_x         (in_x),
        .in_y         (in_y),
        .priority_num (priority_num),
        .play_done    (play_done),
        .play_go      (play_go),
        .path         (path.searcher)
    );

    kt_playback i_playback (
        .clk       (clk),
        .rst_n     (rst_n),
        .play_go   (play_go),
        .play_done (play_done),
        .out_valid (out_valid),
        .out_x     (out_x),
        .out_y     (out_y),
        .move_out  (move_out),
        .path      (path.player)
    );

endmodule

`default_nettype wire

// File: logic/kt_playback.sv
`timescale 1ns/1ps
`default_nettype none

module kt_playback (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        play_go,
    output logic                       play_done,
    output logic                       out_valid,
    output logic [kt_pkg::COORD_W-1:0] out_x,
    output logic [kt_pkg::COORD_W-1:0] out_y,
    output logic [kt_pkg::STEP_W-1:0]  move_out,
    kt_path_if.player                  path
);

    // last step already sent, zero between runs
    logic [kt_pkg::STEP_W-1:0] step;
    logic                      active;

    assign active       = play_go && (step != kt_pkg::NUM_SQUARES);
    assign path.rd_step = step + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step      <= '0;
            play_done <= 1'b0;
            out_valid <= 1'b0;
            out_x     <= '0;
            out_y     <= '0;
            move_out  <= '0;
        end else if (active) begin
            step      <= path.rd_step;
            play_done <= (path.rd_step == kt_pkg::NUM_SQUARES);
            out_valid <= 1'b1;
            out_x     <= path.rd_x;
            out_y     <= path.rd_y;
            move_out  <= path.rd_step;
        end else begin
            // hold the final count until search leaves the play state
            if (!play_go) begin
                step <= '0;
            end
            play_done <= 1'b0;
            out_valid <= 1'b0;
            out_x     <= '0;
            out_y     <= '0;
            move_out  <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/kt_search.sv
`timescale 1ns/1ps
`default_nettype none

module kt_search (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_valid,
    input  wire [kt_pkg::COORD_W-1:0]   in_x,
    input  wire [kt_pkg::COORD_W-1:0]   in_y,
    input  wire [kt_pkg::DIR_W-1:0]     priority_num,
    input  wire                         play_done,
    output logic                        play_go,
    kt_path_if.searcher                 path
);

    kt_pkg::search_state_t      state;
    kt_pkg::knight_dir_t        prio;
    kt_pkg::knight_dir_t        cand;
    logic [kt_pkg::TRY_W-1:0]   tried;

    logic [kt_pkg::COORD_W-1:0] tgt_x;
    logic [kt_pkg::COORD_W-1:0] tgt_y;
    logic                       legal;
    logic                       full;
    logic                       exhausted;

    kt_move_gen i_move_gen (
        .cur_x (path.top_x),
        .cur_y (path.top_y),
        .dir   (cand),
        .occ   (path.occ),
        .tgt_x (tgt_x),
        .tgt_y (tgt_y),
        .legal (legal)
    );

    assign full      = (path.depth == kt_pkg::NUM_SQUARES);
    assign exhausted = (tried == kt_pkg::NUM_DIRS);
    assign play_go   = (state == kt_pkg::ST_PLAY);

    // stack command for this cycle, one action per search cycle
    always_comb begin
        path.op         = kt_pkg::OP_NONE;
        path.push_x     = in_x;
        path.push_y     = in_y;
        path.push_dir   = kt_pkg::DIR_NNW;
        path.push_tried = '0;
        case (state)
            kt_pkg::ST_IDLE: begin
                if (in_valid) begin
                    path.op = kt_pkg::OP_PUSH;
                end
            end
            kt_pkg::ST_LOAD: begin
                if (in_valid) begin
                    path.op       = kt_pkg::OP_PUSH;
                    path.push_dir = kt_pkg::dir_between(path.top_x, path.top_y, in_x, in_y);
                end
            end
            kt_pkg::ST_SEARCH: begin
                if (!full && exhausted) begin
                    path.op = kt_pkg::OP_POP;
                end else if (!full && legal) begin
                    path.op         = kt_pkg::OP_PUSH;
                    path.push_x     = tgt_x;
                    path.push_y     = tgt_y;
                    path.push_dir   = cand;
                    path.push_tried = tried;
                end
            end
            kt_pkg::ST_PLAY: begin
                if (play_done) begin
                    path.op = kt_pkg::OP_CLEAR;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= kt_pkg::ST_IDLE;
            prio  <= kt_pkg::DIR_NNW;
            cand  <= kt_pkg::DIR_NNW;
            tried <= '0;
        end else begin
            case (state)
                kt_pkg::ST_IDLE: begin
                    if (in_valid) begin
                        prio  <= kt_pkg::knight_dir_t'(priority_num);
                        cand  <= kt_pkg::knight_dir_t'(priority_num);
                        tried <= '0;
                        state <= kt_pkg::ST_LOAD;
                    end
                end
                kt_pkg::ST_LOAD: begin
                    if (!in_valid) begin
                        state <= kt_pkg::ST_SEARCH;
                    end
                end
                kt_pkg::ST_SEARCH: begin
                    if (full) begin
                        state <= kt_pkg::ST_PLAY;
                    end else if (exhausted) begin
                        // resume the parent one direction past the square being dropped
                        cand  <= kt_pkg::knight_dir_t'(path.top_dir + 3'd1);
                        tried <= path.top_tried + 4'd1;
                    end else if (legal) begin
                        cand  <= prio;
                        tried <= '0;
                    end else begin
                        cand  <= kt_pkg::knight_dir_t'(cand + 3'd1);
                        tried <= tried + 4'd1;
                    end
                end
                kt_pkg::ST_PLAY: begin
                    if (play_done) begin
                        state <= kt_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/kt_move_gen.sv
`timescale 1ns/1ps
`default_nettype none

module kt_move_gen (
    input  wire                             [kt_pkg::COORD_W-1:0]     cur_x,
    input  wire                             [kt_pkg::COORD_W-1:0]     cur_y,
    input  wire kt_pkg::knight_dir_t                                  dir,
    input  wire                             [kt_pkg::NUM_SQUARES-1:0] occ,
    output logic                            [kt_pkg::COORD_W-1:0]     tgt_x,
    output logic                            [kt_pkg::COORD_W-1:0]     tgt_y,
    output logic                                                      legal
);

    kt_pkg::offset_t sum_x;
    kt_pkg::offset_t sum_y;
    logic            on_board;

    // the extra sign bit catches steps off the low edge
    assign sum_x = $signed({1'b0, cur_x}) + kt_pkg::knight_dx(dir);
    assign sum_y = $signed({1'b0, cur_y}) + kt_pkg::knight_dy(dir);

    assign on_board = (sum_x >= 0) && (sum_x < kt_pkg::BOARD_N) &&
                      (sum_y >= 0) && (sum_y < kt_pkg::BOARD_N);

    assign tgt_x = sum_x[kt_pkg::COORD_W-1:0];
    assign tgt_y = sum_y[kt_pkg::COORD_W-1:0];

    // the occupancy bit is only looked up for squares on the board
    assign legal = on_board ? !occ[kt_pkg::sq_idx(tgt_x, tgt_y)] : 1'b0;

endmodule

`default_nettype wire

// File: logic/kt_path_store.sv
`timescale 1ns/1ps
`default_nettype none

module kt_path_store (
    input wire       clk,
    input wire       rst_n,
    kt_path_if.store path
);

    // entry k holds the square visited at step k
    logic [kt_pkg::COORD_W-1:0]     ent_x     [1:kt_pkg::NUM_SQUARES];
    logic [kt_pkg::COORD_W-1:0]     ent_y     [1:kt_pkg::NUM_SQUARES];
    kt_pkg::knight_dir_t            ent_dir   [1:kt_pkg::NUM_SQUARES];
    logic [kt_pkg::TRY_W-1:0]       ent_tried [1:kt_pkg::NUM_SQUARES];

    logic [kt_pkg::STEP_W-1:0]      depth_q;
    logic [kt_pkg::NUM_SQUARES-1:0] occ_q;
    logic [kt_pkg::STEP_W-1:0]      push_step;
    logic                           has_top;
    logic                           rd_ok;

    assign push_step = depth_q + 1'b1;
    assign has_top   = (depth_q != '0);
    assign rd_ok     = (path.rd_step != '0) && (path.rd_step <= kt_pkg::NUM_SQUARES);

    always_ff @(posedge clk) begin
        if (path.op == kt_pkg::OP_PUSH) begin
            ent_x[push_step]     <= path.push_x;
            ent_y[push_step]     <= path.push_y;
            ent_dir[push_step]   <= path.push_dir;
            ent_tried[push_step] <= path.push_tried;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            depth_q <= '0;
            occ_q   <= '0;
        end else if (path.op == kt_pkg::OP_PUSH) begin
            depth_q <= push_step;
            occ_q[kt_pkg::sq_idx(path.push_x, path.push_y)] <= 1'b1;
        end else if (path.op == kt_pkg::OP_POP) begin
            // the square being left becomes free again
            depth_q <= depth_q - 1'b1;
            occ_q[kt_pkg::sq_idx(path.top_x, path.top_y)] <= 1'b0;
        end else if (path.op == kt_pkg::OP_CLEAR) begin
            depth_q <= '0;
            occ_q   <= '0;
        end
    end

    assign path.depth = depth_q;
    assign path.occ   = occ_q;

    // an empty stack shows a zero top entry
    assign path.top_x     = has_top ? ent_x[depth_q] : '0;
    assign path.top_y     = has_top ? ent_y[depth_q] : '0;
    assign path.top_dir   = has_top ? ent_dir[depth_q] : kt_pkg::DIR_NNW;
    assign path.top_tried = has_top ? ent_tried[depth_q] : '0;

    assign path.rd_x = rd_ok ? ent_x[path.rd_step] : '0;
    assign path.rd_y = rd_ok ? ent_y[path.rd_step] : '0;

endmodule

`default_nettype wire

// File: logic/kt_path_if.sv
`timescale 1ns/1ps
`default_nettype none

interface kt_path_if;

    // stack commands from the search controller
    kt_pkg::stack_op_t                 op;
    logic [kt_pkg::COORD_W-1:0]        push_x;
    logic [kt_pkg::COORD_W-1:0]        push_y;
    kt_pkg::knight_dir_t               push_dir;
    logic [kt_pkg::TRY_W-1:0]          push_tried;

    // playback read address
    logic [kt_pkg::STEP_W-1:0]         rd_step;

    // store state, top entry and the random read
    logic [kt_pkg::STEP_W-1:0]         depth;
    logic [kt_pkg::NUM_SQUARES-1:0]    occ;
    logic [kt_pkg::COORD_W-1:0]        top_x;
    logic [kt_pkg::COORD_W-1:0]        top_y;
    kt_pkg::knight_dir_t               top_dir;
    logic [kt_pkg::TRY_W-1:0]          top_tried;
    logic [kt_pkg::COORD_W-1:0]        rd_x;
    logic [kt_pkg::COORD_W-1:0]        rd_y;

    modport searcher (
        output op, push_x, push_y, push_dir, push_tried,
        input  depth, occ, top_x, top_y, top_dir, top_tried
    );

    modport player (
        output rd_step,
        input  rd_x, rd_y
    );

    modport store (
        input  op, push_x, push_y, push_dir, push_tried, rd_step,
        output depth, occ, top_x, top_y, top_dir, top_tried, rd_x, rd_y
    );

endinterface

`default_nettype wire

// File: logic/kt_pkg.sv
`default_nettype none

package kt_pkg;

    localparam int BOARD_N     = 5;
    localparam int NUM_SQUARES = BOARD_N * BOARD_N;
    localparam int NUM_DIRS    = 8;
    localparam int COORD_W     = 3;
    localparam int STEP_W      = 5;
    localparam int DIR_W       = 3;
    localparam int TRY_W       = 4;

    // one bit wider than a coordinate so a square plus a knight offset stays signed
    typedef logic signed [COORD_W:0] offset_t;

    // clockwise from north, each named by its long leg first
    typedef enum logic [DIR_W-1:0] {
        DIR_NNW,
        DIR_NNE,
        DIR_ENE,
        DIR_ESE,
        DIR_SSE,
        DIR_SSW,
        DIR_WSW,
        DIR_WNW
    } knight_dir_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_PUSH,
        OP_POP,
        OP_CLEAR
    } stack_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SEARCH,
        ST_PLAY
    } search_state_t;

    function automatic offset_t knight_dx(input knight_dir_t dir);
        case (dir)
            DIR_NNW, DIR_SSW: return offset_t'(-1);
            DIR_NNE, DIR_SSE: return offset_t'(1);
            DIR_ENE, DIR_ESE: return offset_t'(2);
            default:          return offset_t'(-2);
        endcase
    endfunction

    function automatic offset_t knight_dy(input knight_dir_t dir);
        case (dir)
            DIR_NNW, DIR_NNE: return offset_t'(2);
            DIR_ENE, DIR_WNW: return offset_t'(1);
            DIR_ESE, DIR_WSW: return offset_t'(-1);
            default:          return offset_t'(-2);
        endcase
    endfunction

    // occupancy bit of a square, rows of BOARD_N along x
    function automatic logic [STEP_W-1:0] sq_idx(input logic [COORD_W-1:0] x,
                                                 input logic [COORD_W-1:0] y);
        return STEP_W'(y * BOARD_N + x);
    endfunction

    // the direction that takes the knight from (px, py) to (nx, ny)
    function automatic knight_dir_t dir_between(input logic [COORD_W-1:0] px,
                                                input logic [COORD_W-1:0] py,
                                                input logic [COORD_W-1:0] nx,
                                                input logic [COORD_W-1:0] ny);
        offset_t     dx;
        offset_t     dy;
        knight_dir_t found;
        dx    = $signed({1'b0, nx}) - $signed({1'b0, px});
        dy    = $signed({1'b0, ny}) - $signed({1'b0, py});
        found = DIR_NNW;
        for (int i = 0; i < NUM_DIRS; i++) begin
            if (knight_dx(knight_dir_t'(i)) == dx && knight_dy(knight_dir_t'(i)) == dy) begin
                found = knight_dir_t'(i);
            end
        end
        return found;
    endfunction

endpackage

`default_nettype wire
